// File: build.f
+incdir+.
range_pkg.sv
range_intake.sv
range_merge_cell.sv
range_merge_chain.sv
range_drain.sv
range_merge_top.sv
range_merge_props.sv
range_merge_tb.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it once and checks the log.
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f build.f --top-module range_merge_tb \
    -o range_merge_sim \
    && ./obj_dir/range_merge_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "=== PASS ===" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: range_merge_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "range_consts.svh"

module range_merge_tb;
    import range_pkg::*;

    typedef logic [2*`RANGE_ID_WIDTH-1:0] pair_t;

    localparam int NUM_ROWS       = 6;
    localparam int MAX_IN         = 10;
    localparam int DRIVE_DELAY    = 2;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * (MAX_IN * 40 + `RANGE_CELLS * 40 + 100);
    localparam logic [31:0] SEED  = 32'hb54f_4676;

    logic        clk;
    logic        reset;
    logic        in_req;
    range_item_t in_item;
    logic        in_ack;
    logic        out_req;
    logic        out_ack;
    range_t      out_range;
    logic        out_done;
    logic        overflow;

    // each entry is {lower, upper}, unused slots are zero.
    pair_t in_tab [NUM_ROWS][MAX_IN] = '{
        '{32'h000a_0014, 32'h001e_0028, 32'h0064_00c8, 32'h01f4_0258, 32'h0,
          32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
        '{32'h000a_0032, 32'h0014_001e, 32'h0028_0050, 32'h00c8_012c, 32'h0064_0096,
          32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
        '{32'h000a_0014, 32'h001e_0028, 32'h0029_0032, 32'h000f_0023, 32'h0,
          32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
        '{32'h000a_0013, 32'h0014_001d, 32'h001e_001e, 32'h0009_0009, 32'h0064_006e,
          32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
        '{32'h0100_0110, 32'h0200_0210, 32'h0300_0310, 32'h0400_0410, 32'h0500_0510,
          32'h0600_0610, 32'h0700_0710, 32'h0800_0810, 32'h0900_0910, 32'h0a00_0a10},
        '{32'h04d2_162e, 32'h0, 32'h0, 32'h0, 32'h0,
          32'h0, 32'h0, 32'h0, 32'h0, 32'h0}
    };
    pair_t exp_tab [NUM_ROWS][MAX_IN] = '{
        '{32'h000a_0014, 32'h001e_0028, 32'h0064_00c8, 32'h01f4_0258, 32'h0,
          32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
        '{32'h000a_0050, 32'h00c8_012c, 32'h0064_0096, 32'h0, 32'h0,
          32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
        '{32'h000a_0028, 32'h0029_0032, 32'h0, 32'h0, 32'h0,
          32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
        '{32'h000a_0013, 32'h0014_001d, 32'h001e_001e, 32'h0009_0009, 32'h0064_006e,
          32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
        '{32'h0100_0110, 32'h0200_0210, 32'h0300_0310, 32'h0400_0410, 32'h0500_0510,
          32'h0600_0610, 32'h0700_0710, 32'h0800_0810, 32'h0, 32'h0},
        '{32'h04d2_162e, 32'h0, 32'h0, 32'h0, 32'h0,
          32'h0, 32'h0, 32'h0, 32'h0, 32'h0}
    };
    int   in_cnt  [NUM_ROWS] = '{4, 5, 4, 5, 10, 1};
    int   exp_cnt [NUM_ROWS] = '{4, 3, 2, 5, 8, 1};
    logic exp_ovf [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

    range_t got [$];
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;

    range_merge_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .in_req    (in_req),
        .in_item   (in_item),
        .in_ack    (in_ack),
        .out_req   (out_req),
        .out_ack   (out_ack),
        .out_range (out_range),
        .out_done  (out_done),
        .overflow  (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    // all driving and sampling happens just after a rising edge.
    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic apply_reset();
        reset   = 1'b1;
        in_req  = 1'b0;
        out_ack = 1'b0;
        repeat (8) step();
        reset = 1'b0;
    endtask

    // in_ack follows each edge of in_req after exactly one cycle.
    task automatic send_batch(input int r);
        range_item_t item;
        for (int i = 0; i < in_cnt[r]; i++) begin
            repeat ($urandom % 5) step();
            item.rng  = in_tab[r][i];
            item.last = (i == in_cnt[r] - 1);
            in_item   = item;
            in_req    = 1'b1;
            step();
            checks++;
            if (in_ack !== 1'b1) begin
                errors++;
                $display("mismatch at %0t ns: in_ack got %0b expected 1", $time, in_ack);
            end
            while (!in_ack) step();
            in_req = 1'b0;
            step();
            checks++;
            if (in_ack !== 1'b0) begin
                errors++;
                $display("mismatch at %0t ns: in_ack got %0b expected 0", $time, in_ack);
            end
            while (in_ack) step();
        end
    endtask

    task automatic collect_ranges();
        int delay;
        got.delete();
        while (!out_done) begin
            if (out_req) begin
                got.push_back(out_range);
                delay = $urandom % 8;
                repeat (delay) step();
                out_ack = 1'b1;
                step();
                while (out_req) step();
                out_ack = 1'b0;
            end
            step();
        end
    endtask

    task automatic watch_out_req_after_done();
        for (int k = 0; k < 20; k++) begin
            checks++;
            if (out_req !== 1'b0) begin
                errors++;
                $display("mismatch at %0t ns: out_req got %0b expected 0 after out_done",
                         $time, out_req);
            end
            step();
        end
    endtask

    task automatic check_row(input int r);
        range_t want;
        int     hits;
        checks++;
        if (got.size() != exp_cnt[r]) begin
            errors++;
            $display("mismatch at %0t ns: out_range count got %0d expected %0d",
                     $time, got.size(), exp_cnt[r]);
        end
        checks++;
        if (overflow !== exp_ovf[r]) begin
            errors++;
            $display("mismatch at %0t ns: overflow got %0b expected %0b",
                     $time, overflow, exp_ovf[r]);
        end
        for (int e = 0; e < exp_cnt[r]; e++) begin
            want = exp_tab[r][e];
            hits = 0;
            for (int g = 0; g < got.size(); g++) begin
                if (got[g] == want) begin
                    hits++;
                end
            end
            checks++;
            if (hits != 1) begin
                errors++;
                $display("batch %0d: range [%0d, %0d] came out %0d times, not once",
                         r, want.lower, want.upper, hits);
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        reset   = 1'b1;
        in_req  = 1'b0;
        in_item = '0;
        out_ack = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_reset();
            fork
                send_batch(r);
                collect_ranges();
            join
            watch_out_req_after_done();
            check_row(r);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: range_merge_props.sv
`timescale 1ns/1ns
`default_nettype none

module range_merge_props (
    input logic              clk,
    input logic              reset,
    input logic              in_req,
    input logic              in_ack,
    input logic              out_req,
    input logic              out_ack,
    input range_pkg::range_t out_range,
    input logic              out_done
);

    // the intake answers a request it saw at the previous edge.
    ack_follows_req: assert property (@(posedge clk) disable iff (reset)
        $rose(in_ack) |-> $past(in_req))
        else $error("in_ack rose without a pending in_req");

    req_held_until_ack: assert property (@(posedge clk) disable iff (reset)
        out_req && !out_ack |=> out_req)
        else $error("out_req dropped before out_ack");

    range_stable_in_req: assert property (@(posedge clk) disable iff (reset)
        out_req |=> !out_req || $stable(out_range))
        else $error("out_range changed while out_req was high");

    done_sticky: assert property (@(posedge clk) disable iff (reset)
        out_done |=> out_done)
        else $error("out_done fell before reset");

endmodule

bind range_merge_top range_merge_props u_props (
    .clk       (clk),
    .reset     (reset),
    .in_req    (in_req),
    .in_ack    (in_ack),
    .out_req   (out_req),
    .out_ack   (out_ack),
    .out_range (out_range),
    .out_done  (out_done)
);

`default_nettype wire

// File: range_merge_top.sv
`timescale 1ns/1ns
`default_nettype none

module range_merge_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_req,
    input  range_pkg::range_item_t in_item,
    output logic                   in_ack,
    output logic                   out_req,
    input  logic                   out_ack,
    output range_pkg::range_t      out_range,
    output logic                   out_done,
    output logic                   overflow
);
    import range_pkg::*;

    range_link_t intake_link;
    range_link_t chain_link;

    range_intake u_intake (
        .clk      (clk),
        .reset    (reset),
        .in_req   (in_req),
        .in_item  (in_item),
        .in_ack   (in_ack),
        .link_out (intake_link)
    );

    range_merge_chain u_chain (
        .clk      (clk),
        .reset    (reset),
        .link_in  (intake_link),
        .link_out (chain_link)
    );

    range_drain u_drain (
        .clk       (clk),
        .reset     (reset),
        .link_in   (chain_link),
        .out_req   (out_req),
        .out_ack   (out_ack),
        .out_range (out_range),
        .out_done  (out_done),
        .overflow  (overflow)
    );

endmodule

`default_nettype wire

// File: range_drain.sv
`timescale 1ns/1ns
`default_nettype none

`include "range_consts.svh"

module range_drain (
    input  logic                   clk,
    input  logic                   reset,
    input  range_pkg::range_link_t link_in,
    output logic                   out_req,
    input  logic                   out_ack,
    output range_pkg::range_t      out_range,
    output logic                   out_done,
    output logic                   overflow
);
    import range_pkg::*;

    localparam int DEPTH = `RANGE_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    range_t           mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    drain_state_t     state;
    range_t           out_range_q;
    logic             done_q;
    logic             overflow_q;
    logic             full;
    logic             push;
    logic             pop;

    assign full = (count == CNT_W'(DEPTH));
    assign push = link_in.valid && link_in.conf_done && !full;
    assign pop  = (state == drain_idle) && (count != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= drain_idle;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            done_q     <= 1'b0;
            overflow_q <= 1'b0;
        end else begin
            // a range falling off the end before the batch is in is lost.
            if (link_in.valid && !link_in.conf_done) begin
                overflow_q <= 1'b1;
            end
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
            case (state)
                drain_idle: begin
                    if (pop) begin
                        state <= drain_req_high;
                    end else if (link_in.dump_done && !link_in.valid) begin
                        done_q <= 1'b1;
                    end
                end
                drain_req_high: begin
                    if (out_ack) begin
                        state <= drain_wait_release;
                    end
                end
                drain_wait_release: begin
                    if (!out_ack) begin
                        state <= drain_idle;
                    end
                end
                default: state <= drain_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= link_in.rng;
        end
        if (pop) begin
            out_range_q <= mem[rd_ptr];
        end
    end

    assign out_req   = (state == drain_req_high);
    assign out_range = out_range_q;
    assign out_done  = done_q;
    assign overflow  = overflow_q;

endmodule

`default_nettype wire

// File: range_merge_chain.sv
`timescale 1ns/1ns
`default_nettype none

`include "range_consts.svh"

module range_merge_chain (
    input  logic                   clk,
    input  logic                   reset,
    input  range_pkg::range_link_t link_in,
    output range_pkg::range_link_t link_out
);
    import range_pkg::*;

    // links[i] feeds cell i, the last entry leaves the chain.
    range_link_t links [`RANGE_CELLS+1];

    assign links[0] = link_in;

    for (genvar i = 0; i < `RANGE_CELLS; i++) begin : g_cell
        range_merge_cell u_cell (
            .clk      (clk),
            .reset    (reset),
            .link_in  (links[i]),
            .link_out (links[i+1])
        );
    end

    assign link_out = links[`RANGE_CELLS];

endmodule

`default_nettype wire

// File: range_merge_cell.sv
`timescale 1ns/1ns
`default_nettype none

module range_merge_cell (
    input  logic                   clk,
    input  logic                   reset,
    input  range_pkg::range_link_t link_in,
    output range_pkg::range_link_t link_out
);
    import range_pkg::*;

    logic   range_set;
    logic   range_dumped;
    id_t    lower_id;
    id_t    upper_id;
    logic   overlap;
    logic   valid_q;
    logic   conf_q;
    logic   dump_q;
    range_t rng_q;
    logic   fwd_in;
    logic   emit_own;

    // touching ranges do not count as overlapping.
    assign overlap = (lower_id <= link_in.rng.upper) && (upper_id >= link_in.rng.lower);

    always_comb begin
        fwd_in   = 1'b0;
        emit_own = 1'b0;
        if (!link_in.conf_done) begin
            fwd_in = link_in.valid && range_set && !overlap;
        end else if (!link_in.dump_done) begin
            // unset cells pass everything on during the dump.
            fwd_in = link_in.valid && (!range_set || !overlap);
        end else if (!range_dumped) begin
            emit_own = range_set;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            range_set <= 1'b0;
        end else if (link_in.valid && !range_set && !link_in.conf_done) begin
            range_set <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (link_in.valid) begin
            if (!range_set) begin
                if (!link_in.conf_done) begin
                    lower_id <= link_in.rng.lower;
                    upper_id <= link_in.rng.upper;
                end
            end else if (overlap) begin
                lower_id <= (link_in.rng.lower < lower_id) ? link_in.rng.lower : lower_id;
                upper_id <= (link_in.rng.upper > upper_id) ? link_in.rng.upper : upper_id;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            range_dumped <= 1'b0;
            valid_q      <= 1'b0;
            conf_q       <= 1'b0;
            dump_q       <= 1'b0;
        end else begin
            valid_q <= fwd_in || emit_own;
            conf_q  <= link_in.conf_done;
            if (link_in.dump_done) begin
                range_dumped <= 1'b1;
            end
            // one cycle after the own range went out.
            if (range_dumped) begin
                dump_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit_own) begin
            rng_q <= '{lower: lower_id, upper: upper_id};
        end else if (fwd_in) begin
            rng_q <= link_in.rng;
        end
    end

    assign link_out = '{valid: valid_q, conf_done: conf_q, dump_done: dump_q, rng: rng_q};

endmodule

`default_nettype wire

// File: range_intake.sv
`timescale 1ns/1ns
`default_nettype none

module range_intake (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_req,
    input  range_pkg::range_item_t in_item,
    output logic                   in_ack,
    output range_pkg::range_link_t link_out
);
    import range_pkg::*;

    intake_state_t state;
    logic          last_seen;
    logic          accept;
    logic          valid_q;
    logic          conf_q;
    logic          dump_q;
    range_t        rng_q;

    // nothing is taken once the final range of the batch is in.
    assign accept = (state == intake_idle) && in_req && !last_seen;

    assign in_ack = (state == intake_wait_release);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= intake_idle;
            last_seen <= 1'b0;
        end else begin
            case (state)
                intake_idle: begin
                    if (accept) begin
                        state     <= intake_wait_release;
                        last_seen <= in_item.last;
                    end
                end
                intake_wait_release: begin
                    if (!in_req) begin
                        state <= intake_idle;
                    end
                end
                default: state <= intake_idle;
            endcase
        end
    end

    // valid pulses with the rise of in_ack, then conf_done and dump_done follow.
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            conf_q  <= 1'b0;
            dump_q  <= 1'b0;
        end else begin
            valid_q <= accept;
            conf_q  <= last_seen;
            dump_q  <= conf_q;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rng_q <= in_item.rng;
        end
    end

    assign link_out = '{valid: valid_q, conf_done: conf_q, dump_done: dump_q, rng: rng_q};

endmodule

`default_nettype wire

// File: range_pkg.sv
`default_nettype none

package range_pkg;

    `include "range_consts.svh"

    typedef logic [`RANGE_ID_WIDTH-1:0] id_t;

    // closed range, both ends inclusive.
    typedef struct packed {
        id_t lower;
        id_t upper;
    } range_t;

    typedef struct packed {
        range_t rng;
        logic   last;
    } range_item_t;

    // one hop of the merge chain.
    typedef struct packed {
        logic   valid;
        logic   conf_done;
        logic   dump_done;
        range_t rng;
    } range_link_t;

    typedef enum logic {
        intake_idle,
        intake_wait_release
    } intake_state_t;

    typedef enum logic [1:0] {
        drain_idle,
        drain_req_high,
        drain_wait_release
    } drain_state_t;

endpackage

`default_nettype wire

// File: range_consts.svh
`ifndef RANGE_CONSTS_SVH
`define RANGE_CONSTS_SVH

// width of one id in bits.
`define RANGE_ID_WIDTH 16

// merge cells in the chain.
`define RANGE_CELLS 8

// the dump yields at most one range per cell.
`define RANGE_FIFO_DEPTH `RANGE_CELLS

`endif
